// File: rtl/videoPkg.sv
package videoPkg;

	typedef logic [9:0]  coord_t;
	typedef logic [11:0] memAddr_t;
	typedef logic [15:0] memWord_t;
	typedef logic [23:0] rgb_t;
	typedef logic [3:0]  digit_t;

	// 640x480 raster, counted in pixel periods
	localparam int H_ACTIVE = 640;
	localparam int H_FRONT  = 16;
	localparam int H_SYNC   = 96;
	localparam int H_BACK   = 48;
	localparam int H_TOTAL  = H_ACTIVE + H_FRONT + H_SYNC + H_BACK;
	localparam int H_SYNC_START = H_ACTIVE + H_FRONT;
	localparam int H_SYNC_END   = H_SYNC_START + H_SYNC;

	localparam int V_ACTIVE = 480;
	localparam int V_FRONT  = 10;
	localparam int V_SYNC   = 2;
	localparam int V_BACK   = 33;
	localparam int V_TOTAL  = V_ACTIVE + V_FRONT + V_SYNC + V_BACK;
	localparam int V_SYNC_START = V_ACTIVE + V_FRONT;
	localparam int V_SYNC_END   = V_SYNC_START + V_SYNC;

	// glyph format, five 3-bit pixels per word, bit 15 spare
	localparam int PIXELS_PER_WORD = 5;
	localparam int GLYPH_WIDTH     = 40;
	localparam int GLYPH_HEIGHT    = 40;
	localparam int WORDS_PER_ROW   = 8;
	localparam int WORDS_PER_GLYPH = 320;

	typedef struct packed {
		coord_t hCount;
		coord_t vCount;
		logic   bright;
		logic   hSync; // active low
		logic   vSync; // active low
		logic   pixelEn;
	} rasterPos_t;

	typedef struct packed {
		logic     wrEn;
		memAddr_t addr;
		memWord_t data;
	} hostWrite_t;

	typedef struct packed {
		logic pixelValid;
		logic bright;
		logic hSync;
		logic vSync;
		rgb_t rgb;
	} videoOut_t;

	typedef enum logic [2:0] {
		IDLE,
		FETCH_HUN,
		FETCH_TEN,
		FETCH_ONE,
		WAIT_DIGIT,
		ACTIVE
	} rendState_t;

endpackage

// File: rtl/rasterTiming.sv
module rasterTiming import videoPkg::*; #(
	parameter int PIXEL_DIV = 4
) (
	input  logic       clk,
	input  logic       reset,
	output rasterPos_t raster
);

	localparam int DIV_W = $clog2(PIXEL_DIV);

	logic [DIV_W-1:0] divCount;
	logic             divWrap;
	coord_t           nextH;
	coord_t           nextV;

	assign divWrap = (divCount == DIV_W'(PIXEL_DIV - 1));

	// position after the current pixel
	always_comb begin
		nextH = raster.hCount + 1'b1;
		nextV = raster.vCount;
		if (raster.hCount == coord_t'(H_TOTAL - 1)) begin
			nextH = '0;
			if (raster.vCount == coord_t'(V_TOTAL - 1))
				nextV = '0;
			else
				nextV = raster.vCount + 1'b1;
		end
	end

	// syncs and bright are decoded from nextH/nextV so they stay aligned with the counters
	always_ff @(posedge clk) begin
		if (!reset) begin
			divCount <= '0;
			raster.pixelEn <= 1'b0;
			raster.hCount <= '0;
			raster.vCount <= '0;
			raster.bright <= 1'b1; // (0,0) is visible
			raster.hSync <= 1'b1;
			raster.vSync <= 1'b1;
		end else begin
			if (divWrap)
				divCount <= '0;
			else
				divCount <= divCount + 1'b1;
			raster.pixelEn <= divWrap;

			if (raster.pixelEn) begin
				raster.hCount <= nextH;
				raster.vCount <= nextV;
				raster.bright <= (nextH < coord_t'(H_ACTIVE)) && (nextV < coord_t'(V_ACTIVE));
				raster.hSync <= !((nextH >= coord_t'(H_SYNC_START)) &&
					(nextH < coord_t'(H_SYNC_END)));
				raster.vSync <= !((nextV >= coord_t'(V_SYNC_START)) &&
					(nextV < coord_t'(V_SYNC_END)));
			end
		end
	end

endmodule

// File: rtl/glyphMemory.sv
module glyphMemory import videoPkg::*; (
	input  logic       clk,
	input  hostWrite_t host,
	input  memAddr_t   rdAddr,
	output memWord_t   rdData
);

	localparam int DEPTH = 2 ** $bits(memAddr_t);

	// count digits and glyph bitmaps share this array
	memWord_t mem [DEPTH];

	always_ff @(posedge clk) begin
		if (host.wrEn)
			mem[host.addr] <= host.data;
		rdData <= mem[rdAddr]; // old data on a same-address write
	end

endmodule

// File: rtl/digitRenderer.sv
module digitRenderer import videoPkg::*; #(
	parameter memAddr_t countBase = 12'd0,
	parameter memAddr_t glyphBase = 12'd16,
	parameter coord_t   glyphTop  = 10'd200,
	parameter coord_t   hunLeft   = 10'd240,
	parameter coord_t   tenLeft   = 10'd300,
	parameter coord_t   oneLeft   = 10'd360,
	parameter rgb_t     bgColor   = 24'h202040
) (
	input  logic       clk,
	input  logic       reset,
	input  rasterPos_t raster,
	output memAddr_t   rdAddr,
	input  memWord_t   rdData,
	output videoOut_t  video
);

	localparam coord_t BOX_LEFT [3] = '{hunLeft, tenLeft, oneLeft};

	rendState_t state;
	rendState_t nextState;
	digit_t     digits [3]; // hundreds, tens, ones
	logic       prevVSync;
	logic       vSyncFall;

	// glyph lookup for the current raster position
	logic       inBox;
	coord_t     row;
	coord_t     boxCol;
	digit_t     boxDigit;
	logic [2:0] pixIdx;
	memAddr_t   glyphAddr;

	// first pipeline stage, address is in the memory
	logic       valid1;
	logic       bright1;
	logic       hSync1;
	logic       vSync1;
	logic       inBox1;
	logic [2:0] pixIdx1;

	logic [2:0] pix;
	rgb_t       rgbNext;

	assign vSyncFall = prevVSync && !raster.vSync;

	always_comb begin
		nextState = state;
		case (state)
			IDLE: if (vSyncFall) nextState = FETCH_HUN;
			FETCH_HUN: nextState = FETCH_TEN;
			FETCH_TEN: nextState = FETCH_ONE;
			FETCH_ONE: nextState = WAIT_DIGIT;
			WAIT_DIGIT: nextState = ACTIVE;
			ACTIVE: if (vSyncFall) nextState = FETCH_HUN;
			default: nextState = IDLE;
		endcase
	end

	// each digit lands one clock after its address
	always_ff @(posedge clk) begin
		if (!reset) begin
			state <= IDLE;
			prevVSync <= 1'b1;
			digits <= '{default: '0};
		end else begin
			state <= nextState;
			prevVSync <= raster.vSync;
			case (state)
				FETCH_TEN: digits[0] <= rdData[3:0];
				FETCH_ONE: digits[1] <= rdData[3:0];
				WAIT_DIGIT: digits[2] <= rdData[3:0];
				default: ;
			endcase
		end
	end

	always_comb begin
		inBox = 1'b0;
		boxCol = '0;
		boxDigit = '0;
		row = raster.vCount - glyphTop;
		if (raster.vCount >= glyphTop && row < coord_t'(GLYPH_HEIGHT)) begin
			for (int i = 0; i < 3; i++) begin
				if (!inBox && raster.hCount >= BOX_LEFT[i] &&
						raster.hCount - BOX_LEFT[i] < coord_t'(GLYPH_WIDTH)) begin
					inBox = 1'b1;
					boxCol = raster.hCount - BOX_LEFT[i];
					boxDigit = digits[i];
				end
			end
		end
		pixIdx = 3'(boxCol % PIXELS_PER_WORD);
		glyphAddr = memAddr_t'(glyphBase + boxDigit * WORDS_PER_GLYPH +
			row * WORDS_PER_ROW + boxCol / PIXELS_PER_WORD);
	end

	always_comb begin
		case (state)
			FETCH_HUN: rdAddr = countBase;
			FETCH_TEN: rdAddr = memAddr_t'(countBase + 1);
			FETCH_ONE: rdAddr = memAddr_t'(countBase + 2);
			default: rdAddr = glyphAddr;
		endcase
	end

	always_ff @(posedge clk) begin
		inBox1 <= inBox && (state == ACTIVE);
		pixIdx1 <= pixIdx;
	end

	always_comb begin
		pix = rdData[3 * pixIdx1 +: 3];
		if (!bright1)
			rgbNext = '0;
		else if (inBox1)
			rgbNext = {{8{pix[2]}}, {8{pix[1]}}, {8{pix[0]}}};
		else
			rgbNext = bgColor;
	end

	// two register stages, every video field trails the raster by two clocks
	always_ff @(posedge clk) begin
		if (!reset) begin
			valid1 <= 1'b0;
			bright1 <= 1'b0;
			hSync1 <= 1'b1;
			vSync1 <= 1'b1;
			video.pixelValid <= 1'b0;
			video.bright <= 1'b0;
			video.hSync <= 1'b1;
			video.vSync <= 1'b1;
			video.rgb <= '0;
		end else begin
			valid1 <= raster.pixelEn && (state == ACTIVE);
			bright1 <= raster.bright;
			hSync1 <= raster.hSync;
			vSync1 <= raster.vSync;
			// a pixel caught by the digit fetch is dropped
			video.pixelValid <= valid1 && (nextState == ACTIVE);
			video.bright <= bright1;
			video.hSync <= hSync1;
			video.vSync <= vSync1;
			video.rgb <= rgbNext;
		end
	end

endmodule

// File: rtl/counterDisplay.sv
module counterDisplay import videoPkg::*; #(
	parameter int       PIXEL_DIV = 4,
	parameter memAddr_t countBase = 12'd0,
	parameter memAddr_t glyphBase = 12'd16,
	parameter coord_t   glyphTop  = 10'd200,
	parameter coord_t   hunLeft   = 10'd240,
	parameter coord_t   tenLeft   = 10'd300,
	parameter coord_t   oneLeft   = 10'd360,
	parameter rgb_t     bgColor   = 24'h202040
) (
	input  logic       clk,
	input  logic       reset,
	input  hostWrite_t host,
	output videoOut_t  video
);

	rasterPos_t raster;
	memAddr_t   rdAddr;
	memWord_t   rdData;

	rasterTiming #(
		.PIXEL_DIV(PIXEL_DIV)
	) i_timing (
		.clk(clk),
		.reset(reset),
		.raster(raster)
	);

	// host writes and renderer reads share one array
	glyphMemory i_memory (
		.clk(clk),
		.host(host),
		.rdAddr(rdAddr),
		.rdData(rdData)
	);

	digitRenderer #(
		.countBase(countBase),
		.glyphBase(glyphBase),
		.glyphTop(glyphTop),
		.hunLeft(hunLeft),
		.tenLeft(tenLeft),
		.oneLeft(oneLeft),
		.bgColor(bgColor)
	) i_renderer (
		.clk(clk),
		.reset(reset),
		.raster(raster),
		.rdAddr(rdAddr),
		.rdData(rdData),
		.video(video)
	);

endmodule

// File: tests/counterDisplay_asserts.sv
module rendererAsserts import videoPkg::*; (
	input logic       clk,
	input logic       reset,
	input videoOut_t  video,
	input rendState_t state
);

	int failCount = 0;

	pulseWidth: assert property (@(posedge clk) disable iff (!reset)
		video.pixelValid |=> !video.pixelValid)
	else begin
		failCount++;
		$error("pixelValid held high for more than one clock");
	end

	// one pixel per PIXEL_DIV clocks, never closer than 3
	pulseSpacing: assert property (@(posedge clk) disable iff (!reset)
		video.pixelValid |-> !$past(video.pixelValid, 1) && !$past(video.pixelValid, 2))
	else begin
		failCount++;
		$error("pixelValid pulses closer than 3 clocks");
	end

	activeOnly: assert property (@(posedge clk) disable iff (!reset)
		video.pixelValid |-> state == ACTIVE)
	else begin
		failCount++;
		$error("pixelValid while the renderer is not in ACTIVE");
	end

endmodule

bind digitRenderer rendererAsserts i_asserts (
	.clk(clk),
	.reset(reset),
	.video(video),
	.state(state)
);

// File: tests/displayChecker.sv
module displayChecker import videoPkg::*; #(
	parameter int   countBase = 0,
	parameter int   glyphBase = 16,
	parameter int   glyphTop  = 200,
	parameter int   hunLeft   = 240,
	parameter int   tenLeft   = 300,
	parameter int   oneLeft   = 360,
	parameter rgb_t bgColor   = 24'h202040
) (
	input  logic       clk,
	input  logic       reset,
	input  hostWrite_t host,
	input  videoOut_t  video,
	output int         rgbErrors,
	output int         otherErrors,
	output int         framesChecked,
	output int         pixelsChecked
);

	localparam int BOX_LEFTS [3] = '{hunLeft, tenLeft, oneLeft};
	localparam int FRAME_PIXELS = H_ACTIVE * V_ACTIVE;

	memWord_t shadow [4096]; // mirror of the DUT memory
	digit_t   frameDigits [3];
	logic     resetSeen = 1'b0;
	logic     armed; // first frame start seen
	logic     hSyncArmed;
	logic     prevVSync;
	logic     prevHSync;
	int       x;
	int       y;
	int       brightCount;
	int       hSyncPixels;
	int       box;
	rgb_t     expected;

	function automatic int boxIndex(int px, int py);
		boxIndex = -1;
		if (py >= glyphTop && py < glyphTop + GLYPH_HEIGHT) begin
			for (int i = 0; i < 3; i++) begin
				if (px >= BOX_LEFTS[i] && px < BOX_LEFTS[i] + GLYPH_WIDTH)
					boxIndex = i;
			end
		end
	endfunction

	function automatic rgb_t expectedRgb(int px, int py, int b);
		int         col;
		int         row;
		memAddr_t   addr;
		logic [2:0] bits;
		if (b < 0)
			return bgColor;
		col = px - BOX_LEFTS[b];
		row = py - glyphTop;
		addr = memAddr_t'(glyphBase + int'(frameDigits[b]) * WORDS_PER_GLYPH +
			row * WORDS_PER_ROW + col / PIXELS_PER_WORD);
		bits = 3'(shadow[addr] >> (3 * (col % PIXELS_PER_WORD))); // r g b, msb first
		return {{8{bits[2]}}, {8{bits[1]}}, {8{bits[0]}}};
	endfunction

	task automatic reportMismatch(string name, int px, int py, rgb_t exp, rgb_t act);
		$display("FAILED %s at x=%0d y=%0d: expected %06h, actual %06h",
			name, px, py, exp, act);
		rgbErrors++;
	endtask

	always @(posedge clk) begin
		if (!reset) begin
			if (!resetSeen) begin
				rgbErrors = 0;
				otherErrors = 0;
				framesChecked = 0;
				pixelsChecked = 0;
			end else if (video.pixelValid !== 1'b0 || video.hSync !== 1'b1 ||
					video.vSync !== 1'b1) begin
				$display("error: video outputs are not idle during reset");
				otherErrors++;
			end
			resetSeen = 1'b1;
			armed = 1'b0;
			hSyncArmed = 1'b0;
			prevVSync = 1'b1;
			prevHSync = 1'b1;
		end else begin
			if (host.wrEn)
				shadow[host.addr] = host.data;

			// frame start, digits for the coming frame
			if (prevVSync && !video.vSync) begin
				if (armed) begin
					if (brightCount != FRAME_PIXELS) begin
						$display("FAILED frameSize: expected %0d bright pixels, actual %0d",
							FRAME_PIXELS, brightCount);
						otherErrors++;
					end
					framesChecked++;
				end
				armed = 1'b1;
				brightCount = 0;
				x = 0;
				y = 0;
				for (int i = 0; i < 3; i++)
					frameDigits[i] = shadow[memAddr_t'(countBase + i)][3:0];
			end
			if (prevHSync && !video.hSync) begin
				hSyncArmed = armed;
				hSyncPixels = 0;
			end

			if (video.pixelValid) begin
				if (!armed) begin
					$display("error: pixelValid before the first digit fetch");
					otherErrors++;
				end else if (!video.bright) begin
					if (video.rgb !== '0)
						reportMismatch("blanking", x, y, '0, video.rgb);
				end else begin
					box = boxIndex(x, y);
					expected = expectedRgb(x, y, box);
					if (video.rgb !== expected)
						reportMismatch(box < 0 ? "background" : "glyph", x, y,
							expected, video.rgb);
					pixelsChecked++;
					brightCount++;
					x++;
					if (x == H_ACTIVE) begin
						x = 0;
						y++;
					end
				end
				if (hSyncArmed && !video.hSync)
					hSyncPixels++;
			end

			if (!prevHSync && video.hSync && hSyncArmed && hSyncPixels != H_SYNC) begin
				$display("FAILED hSyncWidth: expected %0d pixels, actual %0d",
					H_SYNC, hSyncPixels);
				otherErrors++;
			end
			prevVSync = video.vSync;
			prevHSync = video.hSync;
		end
	end

endmodule

// File: tests/counterDisplayTb.sv
module counterDisplayTb import videoPkg::*; ();

	localparam int       PIXEL_DIV = 4;
	localparam memAddr_t countBase = 12'd0;
	localparam memAddr_t glyphBase = 12'd16;
	localparam coord_t   glyphTop  = 10'd200;
	localparam coord_t   hunLeft   = 10'd240;
	localparam coord_t   tenLeft   = 10'd300;
	localparam coord_t   oneLeft   = 10'd360;
	localparam rgb_t     bgColor   = 24'h202040;

	localparam int SEED = 17;
	localparam int TEST_FRAMES = 4;
	localparam int LOAD_WRITES = 10 * WORDS_PER_GLYPH + 3;
	localparam int FRAME_CLOCKS = H_TOTAL * V_TOTAL * PIXEL_DIV;
	localparam int TIMEOUT_CLOCKS = LOAD_WRITES + 5 * FRAME_CLOCKS;

	logic       clk;
	logic       reset;
	hostWrite_t host;
	videoOut_t  video;
	int         rgbErrors;
	int         otherErrors;
	int         framesChecked;
	int         pixelsChecked;

	counterDisplay #(
		.PIXEL_DIV(PIXEL_DIV),
		.countBase(countBase),
		.glyphBase(glyphBase),
		.glyphTop(glyphTop),
		.hunLeft(hunLeft),
		.tenLeft(tenLeft),
		.oneLeft(oneLeft),
		.bgColor(bgColor)
	) i_dut (
		.clk(clk),
		.reset(reset),
		.host(host),
		.video(video)
	);

	displayChecker #(
		.countBase(countBase),
		.glyphBase(glyphBase),
		.glyphTop(glyphTop),
		.hunLeft(hunLeft),
		.tenLeft(tenLeft),
		.oneLeft(oneLeft),
		.bgColor(bgColor)
	) i_checker (
		.clk(clk),
		.reset(reset),
		.host(host),
		.video(video),
		.rgbErrors(rgbErrors),
		.otherErrors(otherErrors),
		.framesChecked(framesChecked),
		.pixelsChecked(pixelsChecked)
	);

	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	// one word per clock, back to back calls give a write every clock
	task automatic writeWord(memAddr_t addr, memWord_t data);
		host <= '{wrEn: 1'b1, addr: addr, data: data};
		@(posedge clk);
		host <= '0;
	endtask

	task automatic waitFrameStart();
		logic prev;
		prev = 1'b0;
		@(posedge clk);
		while (!(prev && !video.vSync)) begin
			prev = video.vSync;
			@(posedge clk);
		end
	endtask

	task automatic finishRun();
		int assertFails;
		int total;
		assertFails = i_dut.i_renderer.i_asserts.failCount;
		total = rgbErrors + otherErrors + assertFails;
		if (framesChecked != TEST_FRAMES) begin
			$display("error: %0d frames checked instead of %0d", framesChecked, TEST_FRAMES);
			total++;
		end
		$display("pixels %0d, frames %0d, rgb errors %0d, other errors %0d, assertion failures %0d",
			pixelsChecked, framesChecked, rgbErrors, otherErrors, assertFails);
		if (total == 0)
			$display("=== PASS ===");
		else
			$display("=== FAIL ===");
		$finish;
	endtask

	initial begin
		int d;
		void'($urandom(SEED));
		reset <= 1'b0;
		host <= '0;
		repeat (2) @(posedge clk);
		reset <= 1'b1;
		@(posedge clk);
		for (int i = 0; i < 10 * WORDS_PER_GLYPH; i++)
			writeWord(memAddr_t'(glyphBase + i), memWord_t'($urandom) & 16'h7fff);
		for (int k = 0; k < 3; k++)
			writeWord(memAddr_t'(countBase + k), memWord_t'($urandom_range(0, 9)));

		// new digits land mid frame, shown from the next one
		for (int f = 0; f < TEST_FRAMES; f++) begin
			waitFrameStart();
			for (int k = 0; k < 3; k++) begin
				repeat ($urandom_range(1, 250000)) @(posedge clk);
				while (!video.bright)
					@(posedge clk);
				d = $urandom_range(0, 9);
				writeWord(memAddr_t'(countBase + k), {12'($urandom), 4'(d)}); // junk upper bits
			end
		end
		waitFrameStart();
		repeat (4) @(posedge clk);
		finishRun();
	end

	initial begin
		repeat (TIMEOUT_CLOCKS) @(posedge clk);
		$display("timeout: the run did not finish within %0d clocks", TIMEOUT_CLOCKS);
		$display("=== FAIL ===");
		$finish;
	end

endmodule

// File: counterDisplay.f
rtl/videoPkg.sv
rtl/rasterTiming.sv
rtl/glyphMemory.sv
rtl/digitRenderer.sv
rtl/counterDisplay.sv
tests/counterDisplay_asserts.sv
tests/displayChecker.sv
tests/counterDisplayTb.sv

// File: Makefile
TOP = counterDisplayTb

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"

test:
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) \
		-f counterDisplay.f -Mdir obj_dir
	./obj_dir/V$(TOP) +verilator+error+limit+1000 | \
		awk '{ print } /=== PASS ===/ { ok = 1 } END { exit !ok }'

clean:
	rm -rf obj_dir
